// File: files.f
+incdir+.
trellisPkg.sv
inputConditioner.sv
trellisRegs.sv
dacMonitor.sv
trellisFrontEnd.sv
trellisFrontEndTb.sv

// File: Makefile
# Verilator build for the trellis front end

TOOL     = verilator
FLAGS    = --timing --assert
TOP      = trellisFrontEndTb
FILELIST = files.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -o $(TOP) -f $(FILELIST)
	-./$(OBJDIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: trellisFrontEndTb.sv
// trellis front end testbench

`default_nettype none

`include "trellisConsts.svh"

module trellisFrontEndTb
   import trellisPkg::*;
();

   localparam int SB             = `SAMPLE_BITS;
   localparam int HALF_PERIOD    = 50;
   localparam int DRIVE_DELAY    = 10;
   localparam int RESET_CYCLES   = 16;
   localparam int TIMEOUT_CYCLES = 64;

   // one register access and what it should leave behind
   typedef struct packed {
      logic                      isWrite;
      logic [`REG_ADDR_BITS-1:0] addr;
      logic [`REG_DATA_BITS-1:0] wdata;
      trellisCtrlT               expCtrl;
      logic [`REG_DATA_BITS-1:0] expData;
   } regRowT;

   logic                      clk;
   logic                      reset;
   iqSampleT                  iqIn;
   symStrobesT                strobesIn;
   regBusT                    regBus;
   dacSelectT                 dacSel;
   decoderStatusT             decStatus;
   mfMonitorT                 mfMon;
   iqSampleT                  iqOut;
   symStrobesT                strobesOut;
   trellisCtrlT               ctrl;
   logic [`REG_DATA_BITS-1:0] rdata;
   dacOutT                    dac0;
   dacOutT                    dac1;
   dacOutT                    dac2;

   // reference model of the sample path, two stages deep
   iqSampleT   p1Iq;
   iqSampleT   p2Iq;
   symStrobesT p1Stb;
   symStrobesT p2Stb;
   iqSampleT   expIq;
   iqSampleT   prevIq;
   logic       delayModel;
   logic       slipPending;
   int         drivenSymEn;
   int         seenSymEn;

   logic [31:0] lfsrState;
   regRowT      regTable[$];
   logic [`DAC_SEL_BITS-1:0] selCodes [6];

   trellisFrontEnd u_trellisFrontEnd (.*);

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // --------------------
   // checks
   // --------------------

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkIq(input string name, input iqSampleT got, input iqSampleT exp);
      if (got !== exp) begin
         abortRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic checkStrobes(input string name, input symStrobesT got,
                               input symStrobesT exp);
      if (got !== exp) begin
         abortRun($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   task automatic checkCtrl(input string name, input trellisCtrlT got, input trellisCtrlT exp);
      if (got !== exp) begin
         abortRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic checkData(input string name, input logic [`REG_DATA_BITS-1:0] got,
                            input logic [`REG_DATA_BITS-1:0] exp);
      if (got !== exp) begin
         abortRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic checkDac(input string name, input dacOutT got, input dacOutT exp);
      if (got !== exp) begin
         abortRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   // --------------------
   // stimulus helpers
   // --------------------

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h80200003;
      end
      return s >> 1;
   endfunction

   function automatic logic [31:0] randomBits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsrState = lfsrStep(lfsrState);
         v = {v[30:0], lfsrState[0]};
      end
      return v;
   endfunction

   function automatic iqSampleT randomIq();
      iqSampleT    s;
      logic [31:0] r;
      r = randomBits(SB);
      s.i = r[SB-1:0];
      r = randomBits(SB);
      s.q = r[SB-1:0];
      return s;
   endfunction

   function automatic regRowT makeRow(input logic isWrite, input logic [`REG_ADDR_BITS-1:0] addr,
                                      input logic [`REG_DATA_BITS-1:0] wdata,
                                      input trellisCtrlT expCtrl,
                                      input logic [`REG_DATA_BITS-1:0] expData);
      regRowT row;
      row.isWrite = isWrite;
      row.addr    = addr;
      row.wdata   = wdata;
      row.expCtrl = expCtrl;
      row.expData = expData;
      return row;
   endfunction

   // one clock; check the stream against the model, then drive the next inputs
   task automatic stepCycle(input iqSampleT drvIq, input symStrobesT drvStb);
      symStrobesT modelStb;
      @(posedge clk);
      #DRIVE_DELAY;
      if (p2Stb.sym2xEn) begin
         expIq  = delayModel ? prevIq : p2Iq;
         prevIq = p2Iq;
      end
      checkStrobes("strobesOut", strobesOut, p1Stb);
      checkIq("iqOut", iqOut, expIq);
      if (strobesOut.symEn) seenSymEn++;
      if (drvStb.symEn) drivenSymEn++;
      // first symEn after a request never reaches the decoder
      modelStb = drvStb;
      if (modelStb.symEn && slipPending) begin
         modelStb.symEn = 1'b0;
         slipPending    = 1'b0;
      end
      p2Iq      = p1Iq;
      p2Stb     = p1Stb;
      p1Iq      = drvIq;
      p1Stb     = modelStb;
      iqIn      = drvIq;
      strobesIn = drvStb;
   endtask

   task automatic runStream(input int n, input logic allStrobes);
      logic [31:0] r;
      symStrobesT  stb;
      for (int k = 0; k < n; k++) begin
         r = randomBits(3);
         stb = r[2:0];
         if (!allStrobes) begin
            stb.symEnEven = 1'b0;
            stb.symEn     = 1'b0;
         end
         stepCycle(randomIq(), stb);
      end
   endtask

   // idle cycles until nothing is left in the pipeline
   task automatic flushStream();
      repeat (3) stepCycle('0, '0);
   endtask

   task automatic applyRow(input regRowT row);
      if (row.isWrite) begin
         regBus = '{1'b1, row.addr, row.wdata};
         stepCycle('0, '0);
         regBus.wr = 1'b0;
         checkCtrl("ctrl", ctrl, row.expCtrl);
         delayModel  = row.expCtrl.symbolDelay;
         slipPending = row.expCtrl.slipRequest;
      end else begin
         regBus = '{1'b0, row.addr, '0};
         stepCycle('0, '0);
         checkData("rdata", rdata, row.expData);
      end
   endtask

   function automatic logic [SB-1:0] leftJustify(input logic [SB-1:0] v, input int width);
      return v << (SB - width);
   endfunction

   // expected channel output from the monitor mapping table
   function automatic dacOutT expectedDac(input int chan, input logic [`DAC_SEL_BITS-1:0] sel,
                                          input iqSampleT iq, input symStrobesT stb,
                                          input mfMonitorT mf, input decoderStatusT st);
      dacOutT e;
      if (chan == 2) e = '{st.symEnOut, leftJustify(SB'(st.phaseError), `ROT_BITS)};
      else e = '{st.symEnOut, leftJustify(SB'(st.normalize), 1)};
      case (sel)
         `DAC_SEL_I: begin
            if (chan == 1) e = '{mf.valid, leftJustify(SB'(mf.mfReal), `MF_BITS)};
            else e = '{stb.sym2xEn, iq.i};
         end
         `DAC_SEL_Q: begin
            if (chan == 1) e = '{mf.valid, leftJustify(SB'(mf.mfImag), `MF_BITS)};
            else e = '{stb.sym2xEn, iq.q};
         end
         `DAC_SEL_PHERR: begin
            if (chan == 1) e = '{st.symEnOut, leftJustify(SB'(st.maxAcs), `MAXACS_BITS)};
         end
         `DAC_SEL_INDEX: e = '{st.symEnOut, leftJustify(SB'(st.index), `INDEX_BITS + 1)};
         default: ;
      endcase
      return e;
   endfunction

   // --------------------
   // main sequence
   // --------------------

   initial begin
      logic [31:0] r;
      int          waitCycles;
      iqSampleT    monIq;
      symStrobesT  monStb;
      lfsrState = 32'h6a508c43;
      reset = 1'b1;
      iqIn = '0;
      strobesIn = '0;
      regBus = '0;
      dacSel = '0;
      decStatus = '0;
      mfMon = '0;
      p1Iq = '0;
      p2Iq = '0;
      p1Stb = '0;
      p2Stb = '0;
      expIq = '0;
      prevIq = 'x;
      delayModel = 1'b0;
      slipPending = 1'b0;
      drivenSymEn = 0;
      seenSymEn = 0;
      selCodes = '{`DAC_SEL_I, `DAC_SEL_Q, `DAC_SEL_PHERR, `DAC_SEL_INDEX, 4'd4, 4'd15};

      regTable.push_back(makeRow(1'b0, `TRELLIS_DECAY_ADDR, '0, '0, 32'h0));
      regTable.push_back(makeRow(1'b0, `TRELLIS_CONTROL_ADDR, '0, '0, 32'h0));
      regTable.push_back(makeRow(1'b1, `TRELLIS_DECAY_ADDR, 32'h123456a5,
                                 '{8'ha5, 1'b0, 1'b0, 1'b0}, '0));
      regTable.push_back(makeRow(1'b0, `TRELLIS_DECAY_ADDR, '0, '0, 32'ha5));
      regTable.push_back(makeRow(1'b1, `TRELLIS_CONTROL_ADDR, 32'hfffffff4,
                                 '{8'ha5, 1'b1, 1'b0, 1'b0}, '0));
      regTable.push_back(makeRow(1'b0, `TRELLIS_CONTROL_ADDR, '0, '0, 32'h4));
      regTable.push_back(makeRow(1'b0, 13'h0408, '0, '0, 32'h0));
      regTable.push_back(makeRow(1'b0, 13'h1404, '0, '0, 32'h0));
      regTable.push_back(makeRow(1'b1, 13'h0c00, 32'hff, '{8'ha5, 1'b1, 1'b0, 1'b0}, '0));
      regTable.push_back(makeRow(1'b1, `TRELLIS_CONTROL_ADDR, 32'h1,
                                 '{8'ha5, 1'b0, 1'b0, 1'b1}, '0));
      regTable.push_back(makeRow(1'b1, `TRELLIS_CONTROL_ADDR, 32'h4,
                                 '{8'ha5, 1'b1, 1'b0, 1'b1}, '0));
      regTable.push_back(makeRow(1'b0, `TRELLIS_CONTROL_ADDR, '0, '0, 32'h5));
      regTable.push_back(makeRow(1'b0, `TRELLIS_DECAY_ADDR, '0, '0, 32'ha5));

      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;
      checkCtrl("ctrl", ctrl, '0);
      checkStrobes("strobesOut", strobesOut, '0);
      checkIq("iqOut", iqOut, '0);
      checkData("dac syncs", {29'b0, dac0.sync, dac1.sync, dac2.sync}, '0);

      foreach (regTable[n]) applyRow(regTable[n]);

      // sample path, direct then one sample late
      stepCycle(randomIq(), '{1'b0, 1'b0, 1'b1});
      runStream(24, 1'b0);
      applyRow(makeRow(1'b1, `TRELLIS_CONTROL_ADDR, 32'h6, '{8'ha5, 1'b1, 1'b1, 1'b1}, '0));
      runStream(24, 1'b0);
      flushStream();

      // slip still pending from the register rows
      drivenSymEn = 0;
      seenSymEn = 0;
      waitCycles = 0;
      while (ctrl.slipRequest) begin
         if (waitCycles == TIMEOUT_CYCLES) abortRun("slip request was never cleared");
         runStream(1, 1'b1);
         waitCycles++;
      end
      runStream(10, 1'b1);
      flushStream();
      checkData("dropped symEn count", 32'(drivenSymEn - seenSymEn), 32'h1);
      applyRow(makeRow(1'b0, `TRELLIS_CONTROL_ADDR, '0, '0, 32'h6));

      drivenSymEn = 0;
      seenSymEn = 0;
      runStream(30, 1'b1);
      flushStream();
      checkData("dropped symEn count", 32'(drivenSymEn - seenSymEn), 32'h0);

      // DAC monitor, every select code on all channels
      // I select sees sym2xEn high, Q select sees it low
      stepCycle(randomIq(), '{1'b0, 1'b0, 1'b1});
      stepCycle(randomIq(), '{1'b0, 1'b0, 1'b0});
      foreach (selCodes[n]) begin
         dacSel = '{selCodes[n], selCodes[n], selCodes[n]};
         r = randomBits($bits(decoderStatusT));
         decStatus = r[$bits(decoderStatusT)-1:0];
         r = randomBits($bits(mfMonitorT));
         mfMon = r[$bits(mfMonitorT)-1:0];
         // stream values the monitor registers at the next edge
         monIq  = expIq;
         monStb = p2Stb;
         runStream(1, 1'b0);
         checkDac("dac0", dac0, expectedDac(0, selCodes[n], monIq, monStb, mfMon, decStatus));
         checkDac("dac1", dac1, expectedDac(1, selCodes[n], monIq, monStb, mfMon, decStatus));
         checkDac("dac2", dac2, expectedDac(2, selCodes[n], monIq, monStb, mfMon, decStatus));
      end

      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: trellisFrontEnd.sv
// multi-h SOQPSK trellis front end
// input conditioning, control registers, DAC monitor

`default_nettype none

`include "trellisConsts.svh"

module trellisFrontEnd
   import trellisPkg::*;
(
   input  logic                      clk,
   input  logic                      reset,
   // sample stream from the demodulator
   input  iqSampleT                  iqIn,
   input  symStrobesT                strobesIn,
   // register port
   input  regBusT                    regBus,
   output logic [`REG_DATA_BITS-1:0] rdata,
   // to the external decoder
   output iqSampleT                  iqOut,
   output symStrobesT                strobesOut,
   output trellisCtrlT               ctrl,
   // back from the decoder
   input  decoderStatusT             decStatus,
   input  mfMonitorT                 mfMon,
   // monitor outputs
   input  dacSelectT                 dacSel,
   output dacOutT                    dac0,
   output dacOutT                    dac1,
   output dacOutT                    dac2
);

   // one strobe dropped
   logic slipDone;

   inputConditioner u_inputConditioner (
      .clk         (clk),
      .reset       (reset),
      .iqIn        (iqIn),
      .strobesIn   (strobesIn),
      .slipRequest (ctrl.slipRequest),
      .symbolDelay (ctrl.symbolDelay),
      .iqOut       (iqOut),
      .strobesOut  (strobesOut),
      .slipDone    (slipDone)
   );

   trellisRegs u_trellisRegs (
      .clk      (clk),
      .reset    (reset),
      .regBus   (regBus),
      .slipDone (slipDone),
      .ctrl     (ctrl),
      .rdata    (rdata)
   );

   // monitors the conditioned stream and the decoder results
   dacMonitor u_dacMonitor (
      .clk       (clk),
      .reset     (reset),
      .dacSel    (dacSel),
      .iq        (iqOut),
      .strobes   (strobesOut),
      .mfMon     (mfMon),
      .decStatus (decStatus),
      .dac0      (dac0),
      .dac1      (dac1),
      .dac2      (dac2)
   );

endmodule

`default_nettype wire

// File: dacMonitor.sv
// DAC monitor multiplexer
// three registered channels

`default_nettype none

`include "trellisConsts.svh"

module dacMonitor
   import trellisPkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  dacSelectT     dacSel,
   input  iqSampleT      iq,
   input  symStrobesT    strobes,
   input  mfMonitorT     mfMon,
   input  decoderStatusT decStatus,
   output dacOutT        dac0,
   output dacOutT        dac1,
   output dacOutT        dac2
);

   // candidate sources, already left-justified with their sync
   dacOutT iSrc;
   dacOutT qSrc;
   dacOutT mfRealSrc;
   dacOutT mfImagSrc;
   dacOutT normSrc;
   dacOutT maxAcsSrc;
   dacOutT phErrSrc;
   dacOutT indexSrc;

   dacOutT next0;
   dacOutT next1;
   dacOutT next2;

   // same decode for every channel, only the sources differ
   function automatic dacOutT pickSource(
      input logic [`DAC_SEL_BITS-1:0] sel,
      input dacOutT                   srcI,
      input dacOutT                   srcQ,
      input dacOutT                   srcPherr,
      input dacOutT                   srcIndex,
      input dacOutT                   srcDefault
   );
      dacOutT pick;
      case (sel)
         `DAC_SEL_I:     pick = srcI;
         `DAC_SEL_Q:     pick = srcQ;
         `DAC_SEL_PHERR: pick = srcPherr;
         `DAC_SEL_INDEX: pick = srcIndex;
         default:        pick = srcDefault;
      endcase
      return pick;
   endfunction

   // --------------------
   // source formatting
   // --------------------

   assign iSrc = '{sync: strobes.sym2xEn, data: iq.i};
   assign qSrc = '{sync: strobes.sym2xEn, data: iq.q};

   assign mfRealSrc = '{sync: mfMon.valid,
                        data: {mfMon.mfReal, {(`SAMPLE_BITS-`MF_BITS){1'b0}}}};
   assign mfImagSrc = '{sync: mfMon.valid,
                        data: {mfMon.mfImag, {(`SAMPLE_BITS-`MF_BITS){1'b0}}}};

   // decoder results, all on the decoder's symbol strobe
   assign normSrc = '{sync: decStatus.symEnOut,
                      data: {decStatus.normalize, {(`SAMPLE_BITS-1){1'b0}}}};
   assign maxAcsSrc = '{sync: decStatus.symEnOut,
                        data: {decStatus.maxAcs, {(`SAMPLE_BITS-`MAXACS_BITS){1'b0}}}};
   assign phErrSrc = '{sync: decStatus.symEnOut,
                       data: {decStatus.phaseError, {(`SAMPLE_BITS-`ROT_BITS){1'b0}}}};

   // index sits one bit below the top
   assign indexSrc = '{sync: decStatus.symEnOut,
                       data: {1'b0, decStatus.index,
                              {(`SAMPLE_BITS-`INDEX_BITS-1){1'b0}}}};

   // --------------------
   // channel select
   // --------------------

   assign next0 = pickSource(dacSel.dac0Sel, iSrc, qSrc, normSrc, indexSrc, normSrc);
   assign next1 = pickSource(dacSel.dac1Sel, mfRealSrc, mfImagSrc, maxAcsSrc,
                             indexSrc, normSrc);
   assign next2 = pickSource(dacSel.dac2Sel, iSrc, qSrc, phErrSrc, indexSrc, phErrSrc);

   always_ff @(posedge clk) begin
      dac0.data <= next0.data;
      dac1.data <= next1.data;
      dac2.data <= next2.data;
      if (reset) begin
         dac0.sync <= 1'b0;
         dac1.sync <= 1'b0;
         dac2.sync <= 1'b0;
      end else begin
         dac0.sync <= next0.sync;
         dac1.sync <= next1.sync;
         dac2.sync <= next2.sync;
      end
   end

endmodule

`default_nettype wire

// File: trellisRegs.sv
// trellis control registers

`default_nettype none

`include "trellisConsts.svh"

module trellisRegs
   import trellisPkg::*;
(
   input  logic                      clk,
   input  logic                      reset,
   input  regBusT                    regBus,
   input  logic                      slipDone,
   output trellisCtrlT               ctrl,
   output logic [`REG_DATA_BITS-1:0] rdata
);

   localparam int SPACE_LSB = `REG_ADDR_BITS - `TRELLIS_SPACE_BITS;
   localparam logic [`REG_ADDR_BITS-1:0] SPACE_BASE   = `TRELLIS_SPACE_BASE;
   localparam logic [`REG_ADDR_BITS-1:0] DECAY_ADDR   = `TRELLIS_DECAY_ADDR;
   localparam logic [`REG_ADDR_BITS-1:0] CONTROL_ADDR = `TRELLIS_CONTROL_ADDR;

   // control register bit layout
   localparam int CTRL_SLIP_BIT  = 0;
   localparam int CTRL_DELAY_BIT = 1;
   localparam int CTRL_TB_BIT    = 2;

   logic inSpace;
   logic hitDecay;
   logic hitControl;
   logic wrDecay;
   logic wrControl;

   // --------------------
   // address decode
   // --------------------

   assign inSpace = regBus.addr[`REG_ADDR_BITS-1:SPACE_LSB] ==
                    SPACE_BASE[`REG_ADDR_BITS-1:SPACE_LSB];

   // register offsets within the trellis space
   assign hitDecay   = inSpace &&
                       (regBus.addr[SPACE_LSB-1:0] == DECAY_ADDR[SPACE_LSB-1:0]);
   assign hitControl = inSpace &&
                       (regBus.addr[SPACE_LSB-1:0] == CONTROL_ADDR[SPACE_LSB-1:0]);

   assign wrDecay   = regBus.wr && hitDecay;
   assign wrControl = regBus.wr && hitControl;

   // --------------------
   // registers
   // --------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         ctrl <= '0;
      end else begin
         if (wrDecay) begin
            ctrl.decayFactor <= regBus.wdata[`DECAY_BITS-1:0];
         end
         if (wrControl) begin
            ctrl.tbEnable    <= regBus.wdata[CTRL_TB_BIT];
            ctrl.symbolDelay <= regBus.wdata[CTRL_DELAY_BIT];
         end
         // set by software, cleared only by the conditioner.
         // A new request on the clearing edge is kept
         if (wrControl && regBus.wdata[CTRL_SLIP_BIT]) begin
            ctrl.slipRequest <= 1'b1;
         end else if (slipDone) begin
            ctrl.slipRequest <= 1'b0;
         end
      end
   end

   // --------------------
   // readback
   // --------------------

   always_comb begin
      rdata = '0;
      if (hitDecay) begin
         rdata[`DECAY_BITS-1:0] = ctrl.decayFactor;
      end else if (hitControl) begin
         rdata[CTRL_TB_BIT]    = ctrl.tbEnable;
         rdata[CTRL_DELAY_BIT] = ctrl.symbolDelay;
         rdata[CTRL_SLIP_BIT]  = ctrl.slipRequest;
      end
   end

   // slip handshake with the conditioner
   slipDoneNeedsRequest: assert property (
      @(posedge clk) disable iff (reset)
      slipDone |-> $past(ctrl.slipRequest)
   ) else $error("slipDone without a pending slip request");

endmodule

`default_nettype wire

// File: inputConditioner.sv
// trellis input conditioner
// reclocking, symbol slip and I/Q latch

`default_nettype none

module inputConditioner
   import trellisPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  iqSampleT   iqIn,
   input  symStrobesT strobesIn,
   input  logic       slipRequest,
   input  logic       symbolDelay,
   output iqSampleT   iqOut,
   output symStrobesT strobesOut,
   output logic       slipDone
);

   iqSampleT iqReclk;
   iqSampleT iqDelay;
   logic     dropSymEn;

   // --------------------
   // reclock stage
   // --------------------

   // samples travel with the strobes, one register deep
   always_ff @(posedge clk) begin
      iqReclk <= iqIn;
   end

   // only the first symEn after a request is eaten; while slipDone is
   // high the request is still being cleared, so no second drop
   assign dropSymEn = strobesIn.symEn & slipRequest & ~slipDone;

   always_ff @(posedge clk) begin
      if (reset) begin
         strobesOut <= '0;
         slipDone   <= 1'b0;
      end else begin
         strobesOut.symEnEven <= strobesIn.symEnEven;
         strobesOut.sym2xEn   <= strobesIn.sym2xEn;
         strobesOut.symEn     <= strobesIn.symEn & ~dropSymEn;
         slipDone             <= dropSymEn;
      end
   end

   // --------------------
   // I/Q latch
   // --------------------

   // previous half-symbol sample
   always_ff @(posedge clk) begin
      if (strobesOut.sym2xEn) begin
         iqDelay <= iqReclk;
      end
   end

   // latched pair for the matched filters, optionally one sample late
   always_ff @(posedge clk) begin
      if (reset) begin
         iqOut <= '0;
      end else if (strobesOut.sym2xEn) begin
         if (symbolDelay) begin
            iqOut <= iqDelay;
         end else begin
            iqOut <= iqReclk;
         end
      end
   end

   // --------------------
   // checks
   // --------------------

   // a slip cycle never carries a symbol strobe to the decoder
   slipGapsStrobe: assert property (
      @(posedge clk) disable iff (reset)
      !(slipDone && strobesOut.symEn)
   ) else $error("slipDone with symEn on strobesOut");

endmodule

`default_nettype wire

// File: trellisPkg.sv
// trellis front end types

`default_nettype none

`include "trellisConsts.svh"

package trellisPkg;

   // latched I/Q pair, two's complement
   typedef struct packed {
      logic signed [`SAMPLE_BITS-1:0] i;
      logic signed [`SAMPLE_BITS-1:0] q;
   } iqSampleT;

   // single-cycle symbol timing strobes
   typedef struct packed {
      logic symEnEven;
      logic symEn;
      logic sym2xEn;
   } symStrobesT;

   // register write/read port
   typedef struct packed {
      logic                      wr;
      logic [`REG_ADDR_BITS-1:0] addr;
      logic [`REG_DATA_BITS-1:0] wdata;
   } regBusT;

   // control values driven to the Viterbi decoder
   typedef struct packed {
      logic [`DECAY_BITS-1:0] decayFactor;
      logic                   tbEnable;
      logic                   symbolDelay;
      logic                   slipRequest;
   } trellisCtrlT;

   // results returned by the decoder
   typedef struct packed {
      logic [`INDEX_BITS-1:0]  index;
      logic                    normalize;
      logic [`MAXACS_BITS-1:0] maxAcs;
      logic [`ROT_BITS-1:0]    phaseError;
      logic                    symEnOut;
   } decoderStatusT;

   // p3p3 45 matched filter taps and their strobe
   typedef struct packed {
      logic [`MF_BITS-1:0] mfReal;
      logic [`MF_BITS-1:0] mfImag;
      logic                valid;
   } mfMonitorT;

   typedef struct packed {
      logic                    sync;
      logic [`SAMPLE_BITS-1:0] data;
   } dacOutT;

   typedef struct packed {
      logic [`DAC_SEL_BITS-1:0] dac0Sel;
      logic [`DAC_SEL_BITS-1:0] dac1Sel;
      logic [`DAC_SEL_BITS-1:0] dac2Sel;
   } dacSelectT;

endpackage

`default_nettype wire

// File: trellisConsts.svh
// trellis front end constants
// widths, register map, DAC select codes

`ifndef TRELLIS_CONSTS_SVH
`define TRELLIS_CONSTS_SVH

// datapath widths
`define SAMPLE_BITS          18
`define MF_BITS              10
`define ROT_BITS             8
`define INDEX_BITS           6
`define MAXACS_BITS          10
`define DECAY_BITS           8

// register port
`define REG_ADDR_BITS        13
`define REG_DATA_BITS        32
`define TRELLIS_SPACE_BITS   5
`define TRELLIS_SPACE_BASE   13'h0400
`define TRELLIS_DECAY_ADDR   13'h0400
`define TRELLIS_CONTROL_ADDR 13'h0404

// DAC monitor select codes
`define DAC_SEL_BITS         4
`define DAC_SEL_I            4'd0
`define DAC_SEL_Q            4'd1
`define DAC_SEL_PHERR        4'd2
`define DAC_SEL_INDEX        4'd3

`endif
